/* Makefile */
TOP := tb_mac_tx

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f mac_tx.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/crc32_pkg.sv */
package crc32_pkg;

    import eth_frame_pkg::*;

    ////////////////////
    // crc-32 word
    ////////////////////

    // reflected form of 0x04C11DB7
    localparam logic [31:0] CRC32_POLY_REFL = 32'hEDB8_8320;

    // running crc seen as one word or as four octets
    // octets[0] is the first fcs byte on the wire
    typedef union packed {
        logic [31:0]     value;
        eth_byte_t [3:0] octets;
    } crc_word_u;

    ////////////////////
    // byte update
    ////////////////////

    // one data byte into the crc, lsb first
    function automatic logic [31:0] crc32_next(input logic [31:0] crc, input eth_byte_t data);
        logic [31:0] c;
        c = crc ^ {24'h00_0000, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC32_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

/* design/eth_frame_pkg.sv */
package eth_frame_pkg;

    ////////////////////
    // link level types
    ////////////////////

    // one octet on any byte link
    typedef logic [7:0] eth_byte_t;

    // element 0 is the first octet on the wire
    typedef eth_byte_t [0:5] mac_addr_t;

    // role of a byte between framer and fcs stage
    typedef enum logic [2:0] {
        KIND_PREAMBLE,
        KIND_SFD,
        // both addresses and the length/type field
        KIND_HEADER,
        KIND_PAYLOAD,
        KIND_PAD
    } byte_kind_e;

    // payload byte counter, sized for jumbo frames
    typedef logic [15:0] payload_cnt_t;

endpackage

/* design/frame_link_if.sv */
`timescale 1ns/10ps

// byte link from the framer to the fcs stage, no back-pressure
interface frame_link_if import eth_frame_pkg::*; ();

    logic       valid;
    eth_byte_t  data;
    byte_kind_e kind;
    // final non-fcs byte of a frame
    logic       last;
    // only set together with last
    logic       abort;

    modport src (
        output valid,
        output data,
        output kind,
        output last,
        output abort
    );

    modport dst (
        input valid,
        input data,
        input kind,
        input last,
        input abort
    );

endinterface

/* design/mac_tx.sv */
`timescale 1ns/10ps

module mac_tx import eth_frame_pkg::*; #(
    parameter mac_addr_t SRC_MAC = 48'h02DE_ADBE_EF01,
    parameter mac_addr_t DST_MAC = 48'hFFFF_FFFF_FFFF
) (
    input  logic      clk,
    input  logic      resetn,

    // user byte stream
    input  logic      tx_valid,
    input  logic      tx_last,
    input  eth_byte_t tx_data,
    output logic      tx_ready,

    // gmii transmit pins
    output eth_byte_t gmii_txd,
    output logic      gmii_tx_en,
    output logic      gmii_tx_er
);

    frame_link_if link ();

    // stage one: frame sequencing
    tx_framer #(
        .SRC_MAC (SRC_MAC),
        .DST_MAC (DST_MAC)
    ) u_tx_framer (
        .clk      (clk),
        .resetn   (resetn),
        .tx_valid (tx_valid),
        .tx_last  (tx_last),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .link     (link.src)
    );

    // stage two: crc and gmii register
    tx_fcs u_tx_fcs (
        .clk        (clk),
        .resetn     (resetn),
        .link       (link.dst),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

endmodule

/* design/mac_tx_consts.svh */
`ifndef MAC_TX_CONSTS_SVH
`define MAC_TX_CONSTS_SVH

// field lengths in bytes
`define PREAMBLE_LEN    (7)
`define MAC_ADDR_LEN    (6)
`define LEN_FIELD_LEN   (2)
`define MIN_PAYLOAD_LEN (46)
`define FCS_LEN         (4)
`define IFG_LEN         (12)

// fixed frame bytes
`define PREAMBLE_BYTE   (8'h55)
`define SFD_BYTE        (8'hD5)

// crc start value and final inversion
`define CRC_SEED        (32'hFFFF_FFFF)
`define CRC_XOR_OUT     (32'hFFFF_FFFF)

`endif

/* design/tx_fcs.sv */
`timescale 1ns/10ps

`include "mac_tx_consts.svh"

module tx_fcs import eth_frame_pkg::*, crc32_pkg::*; (
    input  logic      clk,
    input  logic      resetn,

    frame_link_if.dst link,

    output eth_byte_t gmii_txd,
    output logic      gmii_tx_en,
    output logic      gmii_tx_er
);

    crc_word_u  crc_q;
    crc_word_u  fcs_word;
    eth_byte_t  fcs_byte;
    logic [1:0] fcs_cnt;
    logic       fcs_active;

    ////////////////////
    // crc accumulation
    ////////////////////

    always_ff @(posedge clk) begin
        if (link.valid) begin
            if (link.kind == KIND_SFD) begin
                crc_q.value <= `CRC_SEED;
            end else if (link.kind inside {KIND_HEADER, KIND_PAYLOAD, KIND_PAD}) begin
                crc_q.value <= crc32_next(crc_q.value, link.data);
            end
        end
    end

    // inverted crc, picked octet by octet
    always_comb begin
        fcs_word.value = crc_q.value ^ `CRC_XOR_OUT;
        fcs_byte       = fcs_word.octets[fcs_cnt];
    end

    ////////////////////
    // gmii output
    ////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
            fcs_active <= 1'b0;
            fcs_cnt    <= '0;
        end else if (link.valid) begin
            gmii_txd   <= link.data;
            gmii_tx_en <= 1'b1;
            gmii_tx_er <= link.abort;
            // aborted frames get no fcs
            fcs_active <= link.last && !link.abort;
            fcs_cnt    <= '0;
        end else if (fcs_active) begin
            gmii_txd   <= fcs_byte;
            gmii_tx_en <= 1'b1;
            gmii_tx_er <= 1'b0;
            fcs_cnt    <= fcs_cnt + 2'd1;
            if (fcs_cnt == 2'(`FCS_LEN - 1)) begin
                fcs_active <= 1'b0;
            end
        end else begin
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
        end
    end

endmodule

/* design/tx_framer.sv */
`timescale 1ns/10ps

`include "mac_tx_consts.svh"

module tx_framer import eth_frame_pkg::*; #(
    parameter mac_addr_t SRC_MAC = 48'h02DE_ADBE_EF01,
    parameter mac_addr_t DST_MAC = 48'hFFFF_FFFF_FFFF
) (
    input  logic      clk,
    input  logic      resetn,

    input  logic      tx_valid,
    input  logic      tx_last,
    input  eth_byte_t tx_data,
    output logic      tx_ready,

    frame_link_if.src link
);

    // link stays quiet while fcs goes out, then the gap itself
    localparam int GAP_LEN = `FCS_LEN + `IFG_LEN;
    localparam int GAP_W   = $clog2(GAP_LEN);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_SFD,
        ST_DST,
        ST_SRC,
        ST_LENGTH,
        ST_PAYLOAD,
        ST_PAD,
        ST_GAP
    } framer_state_e;

    framer_state_e state_q, state_d;
    logic [2:0]       idx_q, idx_d;
    payload_cnt_t     pay_cnt_q, pay_cnt_d;
    logic [GAP_W-1:0] gap_cnt_q, gap_cnt_d;

    // next link byte
    logic       nxt_valid;
    eth_byte_t  nxt_data;
    byte_kind_e nxt_kind;
    logic       nxt_last;
    logic       nxt_abort;

    ////////////////////
    // sequencing
    ////////////////////

    always_comb begin
        state_d   = state_q;
        idx_d     = idx_q;
        pay_cnt_d = pay_cnt_q;
        gap_cnt_d = '0;
        tx_ready  = 1'b0;
        nxt_valid = 1'b0;
        nxt_data  = '0;
        nxt_kind  = KIND_HEADER;
        nxt_last  = 1'b0;
        nxt_abort = 1'b0;

        case (state_q)
            ST_IDLE: begin
                idx_d = '0;
                if (tx_valid) begin
                    state_d = ST_PREAMBLE;
                end
            end
            ST_PREAMBLE: begin
                nxt_valid = 1'b1;
                nxt_data  = `PREAMBLE_BYTE;
                nxt_kind  = KIND_PREAMBLE;
                if (idx_q == 3'(`PREAMBLE_LEN - 1)) begin
                    idx_d   = '0;
                    state_d = ST_SFD;
                end else begin
                    idx_d = idx_q + 3'd1;
                end
            end
            ST_SFD: begin
                nxt_valid = 1'b1;
                nxt_data  = `SFD_BYTE;
                nxt_kind  = KIND_SFD;
                idx_d     = '0;
                state_d   = ST_DST;
            end
            ST_DST, ST_SRC: begin
                nxt_valid = 1'b1;
                nxt_data  = (state_q == ST_DST) ? DST_MAC[idx_q] : SRC_MAC[idx_q];
                if (idx_q == 3'(`MAC_ADDR_LEN - 1)) begin
                    idx_d   = '0;
                    state_d = (state_q == ST_DST) ? ST_SRC : ST_LENGTH;
                end else begin
                    idx_d = idx_q + 3'd1;
                end
            end
            ST_LENGTH: begin
                tx_ready  = 1'b1;
                nxt_valid = 1'b1;
                nxt_data  = tx_data;
                pay_cnt_d = '0;
                if (idx_q == 3'(`LEN_FIELD_LEN - 1)) begin
                    idx_d = '0;
                    // no payload at all, go straight to padding
                    state_d = tx_last ? ST_PAD : ST_PAYLOAD;
                end else begin
                    idx_d = idx_q + 3'd1;
                end
            end
            ST_PAYLOAD: begin
                tx_ready  = 1'b1;
                nxt_valid = 1'b1;
                nxt_data  = tx_data;
                nxt_kind  = KIND_PAYLOAD;
                pay_cnt_d = pay_cnt_q + 1'b1;
                if (tx_last) begin
                    if (pay_cnt_q < payload_cnt_t'(`MIN_PAYLOAD_LEN - 1)) begin
                        state_d = ST_PAD;
                    end else begin
                        nxt_last = 1'b1;
                        state_d  = ST_GAP;
                    end
                end
            end
            ST_PAD: begin
                nxt_valid = 1'b1;
                nxt_kind  = KIND_PAD;
                pay_cnt_d = pay_cnt_q + 1'b1;
                if (pay_cnt_q == payload_cnt_t'(`MIN_PAYLOAD_LEN - 1)) begin
                    nxt_last = 1'b1;
                    state_d  = ST_GAP;
                end
            end
            ST_GAP: begin
                idx_d     = '0;
                gap_cnt_d = gap_cnt_q + 1'b1;
                if (gap_cnt_q == GAP_W'(GAP_LEN - 1)) begin
                    gap_cnt_d = '0;
                    state_d   = tx_valid ? ST_PREAMBLE : ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase

        // underrun: user dropped valid before the last byte
        if (!tx_valid && state_q inside {ST_PREAMBLE, ST_SFD, ST_DST, ST_SRC,
                                         ST_LENGTH, ST_PAYLOAD}) begin
            if (state_q == ST_PAYLOAD) begin
                nxt_kind = KIND_PAYLOAD;
            end else begin
                nxt_kind = KIND_HEADER;
            end
            // nothing valid on tx_data here
            if (state_q inside {ST_LENGTH, ST_PAYLOAD}) begin
                nxt_data = '0;
            end
            nxt_last  = 1'b1;
            nxt_abort = 1'b1;
            gap_cnt_d = '0;
            state_d   = ST_GAP;
        end
    end

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q    <= ST_IDLE;
            idx_q      <= '0;
            pay_cnt_q  <= '0;
            gap_cnt_q  <= '0;
            link.valid <= 1'b0;
            link.last  <= 1'b0;
            link.abort <= 1'b0;
        end else begin
            state_q    <= state_d;
            idx_q      <= idx_d;
            pay_cnt_q  <= pay_cnt_d;
            gap_cnt_q  <= gap_cnt_d;
            link.valid <= nxt_valid;
            link.last  <= nxt_last;
            link.abort <= nxt_abort;
        end
    end

    // byte payload of the link
    always_ff @(posedge clk) begin
        link.data <= nxt_data;
        link.kind <= nxt_kind;
    end

endmodule

/* mac_tx.f */
+incdir+design
design/eth_frame_pkg.sv
design/crc32_pkg.sv
design/frame_link_if.sv
design/tx_framer.sv
design/tx_fcs.sv
design/mac_tx.sv
testbench/mac_tx_sva.sv
testbench/tb_mac_tx.sv

/* testbench/mac_tx_sva.sv */
`timescale 1ns/10ps

`include "mac_tx_consts.svh"

module mac_tx_sva import eth_frame_pkg::*; (
    input logic      clk,
    input logic      resetn,
    input logic      tx_ready,
    input eth_byte_t gmii_txd,
    input logic      gmii_tx_en,
    input logic      gmii_tx_er
);

    // bytes already out in this frame, stops at 8
    logic [3:0] en_cnt;
    // idle cycles since the last frame, stops at the gap length
    logic [4:0] idle_cnt;
    logic       seen_frame;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            en_cnt     <= '0;
            idle_cnt   <= '0;
            seen_frame <= 1'b0;
        end else if (gmii_tx_en) begin
            idle_cnt   <= '0;
            seen_frame <= 1'b1;
            if (en_cnt != 4'd8) begin
                en_cnt <= en_cnt + 4'd1;
            end
        end else begin
            en_cnt <= '0;
            if (idle_cnt != 5'(`IFG_LEN)) begin
                idle_cnt <= idle_cnt + 5'd1;
            end
        end
    end

    er_needs_en: assert property (@(posedge clk) disable iff (!resetn)
        gmii_tx_er |-> gmii_tx_en)
        else $error("gmii_tx_er high while gmii_tx_en is low");

    ready_after_gap: assert property (@(posedge clk) disable iff (!resetn)
        seen_frame && !gmii_tx_en && idle_cnt < 5'(`IFG_LEN) |-> !tx_ready)
        else $error("tx_ready high inside the inter-frame gap");

    preamble_bytes: assert property (@(posedge clk) disable iff (!resetn)
        gmii_tx_en && en_cnt < 4'(`PREAMBLE_LEN) |-> gmii_txd == `PREAMBLE_BYTE)
        else $error("wrong preamble byte at frame start");

    sfd_byte: assert property (@(posedge clk) disable iff (!resetn)
        gmii_tx_en && en_cnt == 4'(`PREAMBLE_LEN) |-> gmii_txd == `SFD_BYTE)
        else $error("start-of-frame byte missing after preamble");

endmodule

bind mac_tx mac_tx_sva u_mac_tx_sva (
    .clk        (clk),
    .resetn     (resetn),
    .tx_ready   (tx_ready),
    .gmii_txd   (gmii_txd),
    .gmii_tx_en (gmii_tx_en),
    .gmii_tx_er (gmii_tx_er)
);

/* testbench/tb_mac_tx.sv */
`timescale 1ns/10ps

`include "mac_tx_consts.svh"

module tb_mac_tx import eth_frame_pkg::*, crc32_pkg::*; ();

    localparam mac_addr_t DST_ADDR = 48'hFFFF_FFFF_FFFF;
    localparam mac_addr_t SRC_ADDR = 48'h02DE_ADBE_EF01;
    localparam int NUM_ROWS = 5;
    localparam int TIMEOUT  = 1000;

    logic      clk;
    logic      resetn;
    logic      tx_valid;
    logic      tx_last;
    eth_byte_t tx_data;
    logic      tx_ready;
    eth_byte_t gmii_txd;
    logic      gmii_tx_en;
    logic      gmii_tx_er;

    ////////////////////
    // frame table
    ////////////////////

    // length/type, payload bytes, underrun position (0 = none), next frame follows at once
    logic [15:0] row_len_type [NUM_ROWS] = '{16'h003C, 16'h000A, 16'h0040, 16'h0800, 16'h86DD};
    int          row_pay_len  [NUM_ROWS] = '{60, 10, 64, 50, 48};
    int          row_underrun [NUM_ROWS] = '{0, 0, 5, 0, 0};
    bit          row_chain    [NUM_ROWS] = '{0, 0, 0, 1, 0};

    eth_byte_t pay_pool [$];
    int        pay_off  [NUM_ROWS];

    // gmii monitor results
    eth_byte_t mon_data [$];
    logic      mon_er   [$];
    int        mon_len  [$];
    int        mon_gap  [$];
    int        frames_seen = 0;
    int        idle_cnt    = 0;
    int        cur_len     = 0;
    bit        in_frame    = 0;

    int err_cnt      = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    always #2 clk = ~clk;

    mac_tx #(
        .SRC_MAC (SRC_ADDR),
        .DST_MAC (DST_ADDR)
    ) u_mac_tx (
        .clk        (clk),
        .resetn     (resetn),
        .tx_valid   (tx_valid),
        .tx_last    (tx_last),
        .tx_data    (tx_data),
        .tx_ready   (tx_ready),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

    // collect each frame while tx_en is high
    always @(negedge clk) begin
        if (resetn && gmii_tx_en) begin
            if (!in_frame) begin
                mon_gap.push_back(idle_cnt);
                in_frame = 1;
            end
            mon_data.push_back(gmii_txd);
            mon_er.push_back(gmii_tx_er);
            cur_len++;
            idle_cnt = 0;
        end else begin
            if (in_frame) begin
                mon_len.push_back(cur_len);
                cur_len = 0;
                in_frame = 0;
                frames_seen++;
            end
            idle_cnt++;
        end
    end

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_byte(input string name, input eth_byte_t got, input eth_byte_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input payload_cnt_t got,
                               input payload_cnt_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input int num, input string what, input int errs_before);
        tests_run++;
        if (err_cnt != errs_before) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, what, err_cnt - errs_before);
        end else begin
            $display("test %0d %s: ok", num, what);
        end
    endtask

    // reflected crc-32, one bit at a time
    function automatic logic [31:0] crc_of_frame(input eth_byte_t bytes[$], input int first);
        logic [31:0] crc;
        logic        fb;
        crc = `CRC_SEED;
        for (int i = first; i < bytes.size(); i++) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ bytes[i][b];
                crc = {1'b0, crc[31:1]};
                if (fb) begin
                    crc = crc ^ 32'hEDB8_8320;
                end
            end
        end
        return crc;
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    // called right after a rising edge, returns right after the transfer edge
    task automatic send_byte(input eth_byte_t d, input logic last);
        int waited;
        waited = 0;
        tx_valid <= 1'b1;
        tx_data  <= d;
        tx_last  <= last;
        @(negedge clk);
        while (!tx_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!tx_ready) begin
            $display("timeout: tx_ready never went high for a user byte at %0t", $time);
            err_cnt++;
        end
        @(posedge clk);
    endtask

    task automatic wait_frame(input int count, output bit ok);
        int waited;
        waited = 0;
        while (frames_seen < count && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ok = (frames_seen >= count);
        if (!ok) begin
            $display("timeout: frame %0d never finished on the gmii side at %0t", count, $time);
            err_cnt++;
        end
    endtask

    task automatic drive_frame(input int row);
        int n;
        bit ok;
        n = (row_underrun[row] != 0) ? row_underrun[row] : row_pay_len[row];
        send_byte(row_len_type[row][15:8], 1'b0);
        send_byte(row_len_type[row][7:0], 1'b0);
        for (int i = 0; i < n; i++) begin
            send_byte(pay_pool[pay_off[row] + i], (row_underrun[row] == 0) && (i == n - 1));
        end
        // chained rows keep valid high into the next frame
        if (!row_chain[row]) begin
            tx_valid <= 1'b0;
            tx_last  <= 1'b0;
            wait_frame(row + 1, ok);
            @(posedge clk);
        end
    endtask

    task automatic check_row(input int row);
        eth_byte_t   exp_q [$];
        crc_word_u   fcs;
        eth_byte_t   got_byte;
        logic        got_er;
        int          n_pay;
        int          got_len;
        int          gap;
        bit          abort;
        bit          ok;
        abort = (row_underrun[row] != 0);
        n_pay = abort ? row_underrun[row] : row_pay_len[row];
        for (int i = 0; i < `PREAMBLE_LEN; i++) begin
            exp_q.push_back(`PREAMBLE_BYTE);
        end
        exp_q.push_back(`SFD_BYTE);
        for (int i = 0; i < `MAC_ADDR_LEN; i++) begin
            exp_q.push_back(DST_ADDR[i]);
        end
        for (int i = 0; i < `MAC_ADDR_LEN; i++) begin
            exp_q.push_back(SRC_ADDR[i]);
        end
        exp_q.push_back(row_len_type[row][15:8]);
        exp_q.push_back(row_len_type[row][7:0]);
        for (int i = 0; i < n_pay; i++) begin
            exp_q.push_back(pay_pool[pay_off[row] + i]);
        end
        if (abort) begin
            exp_q.push_back(8'h00);
        end else begin
            for (int i = n_pay; i < `MIN_PAYLOAD_LEN; i++) begin
                exp_q.push_back(8'h00);
            end
            // fcs starts after preamble and sfd
            fcs.value = ~crc_of_frame(exp_q, `PREAMBLE_LEN + 1);
            for (int i = 0; i < `FCS_LEN; i++) begin
                exp_q.push_back(fcs.octets[i]);
            end
        end
        wait_frame(row + 1, ok);
        if (ok) begin
            got_len = mon_len.pop_front();
            gap     = mon_gap.pop_front();
            check_count("frame length", payload_cnt_t'(got_len), payload_cnt_t'(exp_q.size()));
            if (row > 0 && row_chain[row - 1]) begin
                check_count("idle gap", payload_cnt_t'(gap), payload_cnt_t'(`IFG_LEN));
            end
            for (int i = 0; i < got_len; i++) begin
                got_byte = mon_data.pop_front();
                got_er   = mon_er.pop_front();
                if (i < exp_q.size()) begin
                    check_byte($sformatf("gmii_txd[%0d]", i), got_byte, exp_q[i]);
                    check_flag($sformatf("gmii_tx_er[%0d]", i), got_er,
                               abort && (i == exp_q.size() - 1));
                end
            end
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int errs;
        clk      = 1'b0;
        resetn   = 1'b0;
        tx_valid = 1'b0;
        tx_last  = 1'b0;
        tx_data  = '0;
        void'($urandom(32'hd456));
        for (int r = 0; r < NUM_ROWS; r++) begin
            pay_off[r] = pay_pool.size();
            for (int i = 0; i < row_pay_len[r]; i++) begin
                pay_pool.push_back(eth_byte_t'($urandom()));
            end
        end

        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        errs = err_cnt;
        check_flag("tx_ready", tx_ready, 1'b0);
        check_flag("gmii_tx_en", gmii_tx_en, 1'b0);
        check_flag("gmii_tx_er", gmii_tx_er, 1'b0);
        check_byte("gmii_txd", gmii_txd, 8'h00);
        report_test(1, "idle outputs after reset", errs);
        @(posedge clk);

        // driver and checker run side by side
        fork
            begin
                for (int r = 0; r < NUM_ROWS; r++) begin
                    drive_frame(r);
                end
            end
            begin
                for (int r = 0; r < NUM_ROWS; r++) begin
                    errs = err_cnt;
                    check_row(r);
                    report_test(r + 2, $sformatf("len/type %h, %0d payload bytes, underrun %0d",
                                row_len_type[r], row_pay_len[r], row_underrun[r]), errs);
                end
            end
        join

        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
